// ==== Makefile ====
SIM      := verilator
TOP      := lsm_pricer_tb
FILELIST := lsm_pricer.f
OBJDIR   := obj_dir
SIMFLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

// ==== common/lsm_coef_if.sv ====
interface lsm_coef_if #(
    parameter int WIDTH = lsm_pkg::FP_WIDTH
);

    // batch constants, held for the whole batch
    logic signed [WIDTH-1:0] beta0;    // regression intercept
    logic signed [WIDTH-1:0] beta1;    // linear term
    logic signed [WIDTH-1:0] beta2;    // quadratic term
    logic signed [WIDTH-1:0] strike;
    logic signed [WIDTH-1:0] disc;     // one-step discount factor

    modport ctrl (
        output beta0,
        output beta1,
        output beta2,
        output strike,
        output disc
    );

    modport dec (
        input beta0,
        input beta1,
        input beta2,
        input strike,
        input disc
    );

endinterface

// ==== common/lsm_pkg.sv ====
package lsm_pkg;

    // ----------------------------------------
    // fixed-point word format
    // ----------------------------------------
    localparam int FP_WIDTH = 32;   // total bits, signed
    localparam int FP_QFRAC = 16;   // fraction bits, Q15.16 by default

    // ----------------------------------------
    // batch sizing
    // ----------------------------------------
    localparam int PATH_BITS = 12;          // 1 to 4095 paths per batch
    localparam int SUM_GUARD = PATH_BITS;   // sum headroom above one word

    // batch FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2    // one cycle, drives the done strobe
    } ctrl_state_t;

    // largest positive signed value of a word of the given width
    // payoff saturates to this when strike - S overflows
    function automatic logic [63:0] sat_pos_max(input int unsigned width);
        return (64'd1 << (width - 1)) - 64'd1;
    endfunction

endpackage

// ==== lsm_decision/fx_mul.sv ====
module fx_mul #(
    parameter int WIDTH = lsm_pkg::FP_WIDTH,
    parameter int QFRAC = lsm_pkg::FP_QFRAC
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic signed [WIDTH-1:0] a,
    input  logic signed [WIDTH-1:0] b,
    output logic signed [WIDTH-1:0] p
);

    logic signed [2*WIDTH-1:0] full_prod;
    logic signed [2*WIDTH-1:0] scaled;

    // double-width product keeps every bit before rescaling
    assign full_prod = a * b;

    // back to Q format, arithmetic shift rounds toward -inf
    assign scaled = full_prod >>> QFRAC;

    // ----------------------------------------
    // output register, holds on stall
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p <= '0;
        end else if (en) begin
            p <= scaled[WIDTH-1:0];    // upper bits dropped
        end
    end

endmodule

// ==== lsm_decision/lsm_decision.sv ====
module lsm_decision #(
    parameter int WIDTH = lsm_pkg::FP_WIDTH,
    parameter int QFRAC = lsm_pkg::FP_QFRAC
) (
    input  logic                    clk,
    input  logic                    rst_n,
    lsm_coef_if.dec                 coef,
    input  logic                    valid_in,    // accepted path, already qualified
    output logic                    ready_out,
    input  logic signed [WIDTH-1:0] s_t,
    output logic                    valid_out,
    input  logic                    ready_in,
    output logic signed [WIDTH-1:0] pv
);
    import lsm_pkg::*;

    localparam logic signed [WIDTH-1:0] PAY_MAX = WIDTH'(sat_pos_max(WIDTH));
    localparam logic signed [WIDTH-1:0] FX_ONE  = WIDTH'(1) << QFRAC;    // 1.0

    logic adv;    // whole pipe moves together
    logic v1;
    logic v2;
    logic v3;

    // output slot empty or being drained
    assign adv       = !v3 || ready_in;
    assign ready_out = adv;
    assign valid_out = v3;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (adv) begin
            v1 <= valid_in;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // ----------------------------------------
    // stage 1: S^2, beta1*S, payoff
    // ----------------------------------------
    logic signed [WIDTH:0]   diff;    // one extra bit, K - S can overflow
    logic signed [WIDTH-1:0] payoff;
    logic signed [WIDTH-1:0] pay1;
    logic signed [WIDTH-1:0] s_sq;
    logic signed [WIDTH-1:0] b1s;

    assign diff = $signed({coef.strike[WIDTH-1], coef.strike})
                - $signed({s_t[WIDTH-1], s_t});

    always_comb begin
        if (s_t >= coef.strike) begin
            payoff = '0;    // out of the money
        end else if (diff > $signed({1'b0, PAY_MAX})) begin
            payoff = PAY_MAX;
        end else begin
            payoff = diff[WIDTH-1:0];
        end
    end

    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) u_mul_ss (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (adv),
        .a     (s_t),
        .b     (s_t),
        .p     (s_sq)
    );

    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) u_mul_b1s (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (adv),
        .a     (coef.beta1),
        .b     (s_t),
        .p     (b1s)
    );

    always_ff @(posedge clk) begin
        if (adv) begin
            pay1 <= payoff;
        end
    end

    // ----------------------------------------
    // stage 2: beta2*S^2 and beta0 + beta1*S
    // ----------------------------------------
    logic signed [WIDTH-1:0] b2s2;
    logic signed [WIDTH-1:0] base2;
    logic signed [WIDTH-1:0] pay2;

    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) u_mul_b2s2 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (adv),
        .a     (coef.beta2),
        .b     (s_sq),
        .p     (b2s2)
    );

    always_ff @(posedge clk) begin
        if (adv) begin
            base2 <= coef.beta0 + b1s;
            pay2  <= pay1;
        end
    end

    // ----------------------------------------
    // stage 3: exercise or hold
    // ----------------------------------------
    logic signed [WIDTH-1:0] cont;    // continuation estimate
    logic                    exercise;
    logic signed [WIDTH-1:0] mul_a;
    logic signed [WIDTH-1:0] mul_b;

    assign cont     = base2 + b2s2;
    assign exercise = (pay2 >= cont);

    // payoff goes through the same multiplier times 1.0, so the
    // product register is the output register
    assign mul_a = exercise ? pay2 : cont;
    assign mul_b = exercise ? FX_ONE : coef.disc;

    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) u_mul_disc (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (adv),
        .a     (mul_a),
        .b     (mul_b),
        .p     (pv)
    );

    // held result stays put until the consumer takes it
    a_hold_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_out && !ready_in |=> valid_out && $stable(pv)
    ) else $error("pv changed while stalled");

    // clipped payoff reaching the decision stage
    a_payoff_pos: assert property (
        @(posedge clk) disable iff (!rst_n)
        v2 |-> pay2 >= 0
    ) else $error("negative payoff in decision stage");

endmodule

// ==== lsm_pricer.f ====
+incdir+testbench
common/lsm_pkg.sv
common/lsm_coef_if.sv
lsm_decision/fx_mul.sv
lsm_decision/lsm_decision.sv
verilog/path_counter.sv
verilog/lsm_ctrl.sv
verilog/pv_accumulator.sv
verilog/lsm_pricer_top.sv
testbench/lsm_pricer_tb.sv

// ==== testbench/lsm_model.svh ====
`ifndef LSM_MODEL_SVH
`define LSM_MODEL_SVH

// reference model of one time step, included inside the testbench module
// uses WIDTH, QFRAC and SUM_W of the including module

// Q-format product: full product, floor rescale, wrap to one word
function automatic logic signed [WIDTH-1:0] model_mul(
    input logic signed [WIDTH-1:0] a,
    input logic signed [WIDTH-1:0] b
);
    logic signed [2*WIDTH-1:0] a_ext;
    logic signed [2*WIDTH-1:0] b_ext;
    logic signed [2*WIDTH-1:0] prod;
    a_ext = a;
    b_ext = b;
    prod  = a_ext * b_ext;
    prod  = prod >>> QFRAC;
    return prod[WIDTH-1:0];
endfunction

// put payoff max(K - S, 0), clipped to the largest positive word
function automatic logic signed [WIDTH-1:0] model_payoff(
    input logic signed [WIDTH-1:0] strike,
    input logic signed [WIDTH-1:0] spot
);
    longint diff;
    longint top;
    diff = longint'(strike) - longint'(spot);
    top  = (longint'(1) <<< (WIDTH - 1)) - 1;
    if (diff <= 0) begin
        return '0;
    end
    if (diff > top) begin
        return WIDTH'(top);
    end
    return WIDTH'(diff);
endfunction

// regression estimate beta0 + beta1*S + beta2*S^2, wraps like a word
function automatic logic signed [WIDTH-1:0] model_cont(
    input logic signed [WIDTH-1:0] b0,
    input logic signed [WIDTH-1:0] b1,
    input logic signed [WIDTH-1:0] b2,
    input logic signed [WIDTH-1:0] spot
);
    return b0 + model_mul(b1, spot) + model_mul(b2, model_mul(spot, spot));
endfunction

// exercise when payoff is at least the continuation, else discount
function automatic logic signed [WIDTH-1:0] model_value(
    input logic signed [WIDTH-1:0] spot,
    input logic signed [WIDTH-1:0] b0,
    input logic signed [WIDTH-1:0] b1,
    input logic signed [WIDTH-1:0] b2,
    input logic signed [WIDTH-1:0] strike,
    input logic signed [WIDTH-1:0] disc
);
    logic signed [WIDTH-1:0] pay;
    logic signed [WIDTH-1:0] cont;
    pay  = model_payoff(strike, spot);
    cont = model_cont(b0, b1, b2, spot);
    if (pay >= cont) begin
        return pay;
    end
    return model_mul(cont, disc);
endfunction

// batch sum with the value sign-extended to the sum width
function automatic logic signed [SUM_W-1:0] model_sum_add(
    input logic signed [SUM_W-1:0] sum,
    input logic signed [WIDTH-1:0] value
);
    logic signed [SUM_W-1:0] value_ext;
    value_ext = value;
    return sum + value_ext;
endfunction

`endif

// ==== testbench/lsm_pricer_tb.sv ====
module lsm_pricer_tb;
    import lsm_pkg::*;

    localparam int WIDTH    = FP_WIDTH;
    localparam int QFRAC    = FP_QFRAC;
    localparam int CNT_BITS = PATH_BITS;
    localparam int SUM_W    = WIDTH + CNT_BITS;

    `include "lsm_model.svh"

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic [CNT_BITS-1:0]     num_paths;
    logic signed [WIDTH-1:0] beta0;
    logic signed [WIDTH-1:0] beta1;
    logic signed [WIDTH-1:0] beta2;
    logic signed [WIDTH-1:0] strike;
    logic signed [WIDTH-1:0] disc;
    logic                    path_valid;
    logic                    path_ready;
    logic signed [WIDTH-1:0] s_t;
    logic                    pv_valid;
    logic                    pv_ready;
    logic signed [WIDTH-1:0] pv;
    logic                    busy;
    logic                    done;
    logic signed [SUM_W-1:0] pv_sum;

    integer seed;

    // constants of the running batch, as the model sees them
    logic signed [WIDTH-1:0] cur_b0;
    logic signed [WIDTH-1:0] cur_b1;
    logic signed [WIDTH-1:0] cur_b2;
    logic signed [WIDTH-1:0] cur_k;
    logic signed [WIDTH-1:0] cur_disc;

    lsm_pricer_top #(
        .WIDTH    (WIDTH),
        .QFRAC    (QFRAC),
        .CNT_BITS (CNT_BITS)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .num_paths  (num_paths),
        .beta0      (beta0),
        .beta1      (beta1),
        .beta2      (beta2),
        .strike     (strike),
        .disc       (disc),
        .path_valid (path_valid),
        .path_ready (path_ready),
        .s_t        (s_t),
        .pv_valid   (pv_valid),
        .pv_ready   (pv_ready),
        .pv         (pv),
        .busy       (busy),
        .done       (done),
        .pv_sum     (pv_sum)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // error handling and random helpers
    // ----------------------------------------
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // random fixed-point value in [lo, hi) thousandths
    function automatic logic signed [WIDTH-1:0] fx_rand(input int lo_milli, input int hi_milli);
        longint milli;
        milli = longint'(lo_milli) + longint'(rand_below(hi_milli - lo_milli));
        return WIDTH'((milli <<< QFRAC) / 1000);
    endfunction

    task automatic start_batch(input int n);
        cur_b0   = fx_rand(0, 20000);
        cur_b1   = fx_rand(-250, 250);
        cur_b2   = fx_rand(-2, 2);
        cur_k    = fx_rand(80000, 120000);
        cur_disc = fx_rand(950, 1000);
        @(posedge clk);
        start     <= 1'b1;
        num_paths <= CNT_BITS'(n);
        beta0     <= cur_b0;
        beta1     <= cur_b1;
        beta2     <= cur_b2;
        strike    <= cur_k;
        disc      <= cur_disc;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // ----------------------------------------
    // one batch: stream spots, check each result, sum and done
    // ----------------------------------------
    task automatic run_batch(input int n, input int stall_pct, input int bidx);
        logic signed [WIDTH-1:0] spot_q[$];
        logic signed [WIDTH-1:0] exp_q[$];
        logic signed [WIDTH-1:0] exp_v;
        logic signed [WIDTH-1:0] held_pv;
        logic signed [SUM_W-1:0] exp_sum;
        logic                    in_xfer;
        logic                    out_xfer;
        logic                    was_stalled;
        logic                    finished;
        int                      sent;
        int                      rcvd;
        int                      cyc;
        int                      last_out_cyc;
        int                      limit;
        exp_sum      = '0;
        held_pv      = '0;
        sent         = 0;
        rcvd         = 0;
        cyc          = 0;
        last_out_cyc = -10;
        was_stalled  = 1'b0;
        finished     = 1'b0;
        limit        = 12 * n + 100;
        start_batch(n);
        for (int i = 0; i < n; i++) begin
            if (rand_below(16) == 0) begin
                spot_q.push_back(cur_k);    // at the money
            end else begin
                spot_q.push_back(fx_rand(60000, 150000));
            end
        end
        while (!finished) begin
            @(posedge clk);
            in_xfer  = path_valid && path_ready;
            out_xfer = pv_valid && pv_ready;
            if (cyc == 0) begin
                check_eq("busy_after_start", 1, busy);
            end
            if (was_stalled) begin    // held result must not move
                check_eq("pv_valid_held", 1, pv_valid);
                check_eq("pv_held", held_pv, pv);
            end
            was_stalled = pv_valid && !pv_ready;
            held_pv     = pv;
            if (sent == n) begin
                check_eq("path_ready_after_last", 0, path_ready);
            end
            if (in_xfer) begin
                exp_q.push_back(model_value(spot_q.pop_front(), cur_b0, cur_b1, cur_b2,
                                            cur_k, cur_disc));
                sent++;
            end
            if (out_xfer) begin
                if (exp_q.size() == 0) begin
                    $display("result accepted with no matching path in batch %0d", bidx);
                    abort_run();
                end
                exp_v = exp_q.pop_front();
                check_eq("pv", exp_v, pv);
                exp_sum      = model_sum_add(exp_sum, exp_v);
                rcvd++;
                last_out_cyc = cyc;
            end
            if (done) begin
                check_eq("done_delay", last_out_cyc + 1, cyc);
                check_eq("result_count", n, rcvd);
                check_eq("pv_sum", exp_sum, pv_sum);
                finished = 1'b1;
            end
            if (cyc >= limit) begin
                $display("batch %0d did not finish within %0d cycles", bidx, limit);
                abort_run();
            end
            // next cycle's inputs, valid and data held until taken
            if (!(path_valid && !in_xfer)) begin
                if (spot_q.size() > 0 && rand_below(4) != 0) begin
                    path_valid <= 1'b1;
                    s_t        <= spot_q[0];
                end else begin
                    path_valid <= 1'b0;
                end
            end
            pv_ready <= (rand_below(100) >= stall_pct);
            if (cyc == 2) begin    // start while busy, must be ignored
                start     <= 1'b1;
                num_paths <= CNT_BITS'(rand_below(4000) + 1);
                beta0     <= fx_rand(-20000, 20000);
                strike    <= fx_rand(0, 200000);
                disc      <= fx_rand(0, 1000);
            end else begin
                start <= 1'b0;
            end
            cyc++;
        end
        @(posedge clk);
        check_eq("done_one_cycle", 0, done);
        check_eq("busy_after_done", 0, busy);
        check_eq("path_ready_after_done", 0, path_ready);
        check_eq("pv_valid_after_done", 0, pv_valid);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed = 32'h0ed4_755d;
        clk  = 1'b0;
        rst_n      <= 1'b0;
        start      <= 1'b0;
        num_paths  <= '0;
        beta0      <= '0;
        beta1      <= '0;
        beta2      <= '0;
        strike     <= '0;
        disc       <= '0;
        path_valid <= 1'b0;
        s_t        <= '0;
        pv_ready   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_eq("busy_after_reset", 0, busy);
        check_eq("path_ready_after_reset", 0, path_ready);
        check_eq("pv_valid_after_reset", 0, pv_valid);
        check_eq("done_after_reset", 0, done);
        run_batch(1, 0, 0);     // single path
        run_batch(1, 50, 1);
        for (int b = 2; b < 8; b++) begin
            run_batch(2 + rand_below(60), (b % 2 == 1) ? 40 : 0, b);
        end
        run_batch(300, 25, 8);  // long run with back-pressure
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== verilog/lsm_ctrl.sv ====
module lsm_ctrl #(
    parameter int WIDTH    = lsm_pkg::FP_WIDTH,
    parameter int CNT_BITS = lsm_pkg::PATH_BITS
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [CNT_BITS-1:0]     num_paths,
    input  logic signed [WIDTH-1:0] beta0,
    input  logic signed [WIDTH-1:0] beta1,
    input  logic signed [WIDTH-1:0] beta2,
    input  logic signed [WIDTH-1:0] strike,
    input  logic signed [WIDTH-1:0] disc,
    lsm_coef_if.ctrl                coef,
    input  logic                    path_valid,
    input  logic                    dec_ready,
    input  logic                    pv_valid,
    input  logic                    pv_ready,
    input  logic                    in_last,
    input  logic                    out_last,
    output logic                    path_ready,
    output logic                    in_fire,
    output logic                    out_fire,
    output logic                    clear,
    output logic                    busy,
    output logic                    done,
    output logic [CNT_BITS-1:0]     batch_size
);
    import lsm_pkg::*;

    ctrl_state_t state;
    logic        accept_en;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign accept_en  = (state == RUN) && !in_last;
    assign path_ready = accept_en && dec_ready;
    assign in_fire    = path_valid && path_ready;
    assign out_fire   = pv_valid && pv_ready;

    // start only counts in IDLE, same edge as the latch
    assign clear = start && (state == IDLE);
    assign busy  = (state != IDLE);
    assign done  = (state == DONE);

    // ----------------------------------------
    // batch FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            batch_size <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= RUN;
                        batch_size <= num_paths;
                    end
                end
                RUN: begin
                    if (out_fire && out_last) begin
                        state <= DONE;    // last result taken
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // coefficients stay fixed for the whole batch
    always_ff @(posedge clk) begin
        if (clear) begin
            coef.beta0  <= beta0;
            coef.beta1  <= beta1;
            coef.beta2  <= beta2;
            coef.strike <= strike;
            coef.disc   <= disc;
        end
    end

endmodule

// ==== verilog/lsm_pricer_top.sv ====
module lsm_pricer_top #(
    parameter int WIDTH    = lsm_pkg::FP_WIDTH,
    parameter int QFRAC    = lsm_pkg::FP_QFRAC,
    parameter int CNT_BITS = lsm_pkg::PATH_BITS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // batch settings, sampled on start
    input  logic                             start,
    input  logic [CNT_BITS-1:0]              num_paths,
    input  logic signed [WIDTH-1:0]          beta0,
    input  logic signed [WIDTH-1:0]          beta1,
    input  logic signed [WIDTH-1:0]          beta2,
    input  logic signed [WIDTH-1:0]          strike,
    input  logic signed [WIDTH-1:0]          disc,
    // spot price stream
    input  logic                             path_valid,
    output logic                             path_ready,
    input  logic signed [WIDTH-1:0]          s_t,
    // per-path value stream
    output logic                             pv_valid,
    input  logic                             pv_ready,
    output logic signed [WIDTH-1:0]          pv,
    // batch status
    output logic                             busy,
    output logic                             done,
    output logic signed [WIDTH+CNT_BITS-1:0] pv_sum
);

    logic                dec_ready;
    logic                in_fire;
    logic                out_fire;
    logic                clear;
    logic                in_last;
    logic                out_last;
    logic [CNT_BITS-1:0] batch_size;

    lsm_coef_if #(.WIDTH(WIDTH)) coef_bus ();

    lsm_ctrl #(
        .WIDTH    (WIDTH),
        .CNT_BITS (CNT_BITS)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .num_paths  (num_paths),
        .beta0      (beta0),
        .beta1      (beta1),
        .beta2      (beta2),
        .strike     (strike),
        .disc       (disc),
        .coef       (coef_bus.ctrl),
        .path_valid (path_valid),
        .dec_ready  (dec_ready),
        .pv_valid   (pv_valid),
        .pv_ready   (pv_ready),
        .in_last    (in_last),
        .out_last   (out_last),
        .path_ready (path_ready),
        .in_fire    (in_fire),
        .out_fire   (out_fire),
        .clear      (clear),
        .busy       (busy),
        .done       (done),
        .batch_size (batch_size)
    );

    path_counter #(.CNT_BITS(CNT_BITS)) u_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .in_fire   (in_fire),
        .out_fire  (out_fire),
        .num_paths (batch_size),
        .in_last   (in_last),
        .out_last  (out_last)
    );

    lsm_decision #(
        .WIDTH (WIDTH),
        .QFRAC (QFRAC)
    ) u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .coef      (coef_bus.dec),
        .valid_in  (in_fire),
        .ready_out (dec_ready),
        .s_t       (s_t),
        .valid_out (pv_valid),
        .ready_in  (pv_ready),
        .pv        (pv)
    );

    pv_accumulator #(
        .WIDTH    (WIDTH),
        .CNT_BITS (CNT_BITS)
    ) u_acc (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .out_fire (out_fire),
        .pv       (pv),
        .pv_sum   (pv_sum)
    );

endmodule

// ==== verilog/path_counter.sv ====
module path_counter #(
    parameter int CNT_BITS = lsm_pkg::PATH_BITS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  logic                in_fire,
    input  logic                out_fire,
    input  logic [CNT_BITS-1:0] num_paths,
    output logic                in_last,
    output logic                out_last
);

    logic [CNT_BITS-1:0] in_cnt;     // paths accepted
    logic [CNT_BITS-1:0] out_cnt;    // results accepted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_cnt  <= '0;
            out_cnt <= '0;
        end else if (clear) begin
            in_cnt  <= '0;
            out_cnt <= '0;
        end else begin
            if (in_fire) begin
                in_cnt <= in_cnt + 1'b1;
            end
            if (out_fire) begin
                out_cnt <= out_cnt + 1'b1;
            end
        end
    end

    assign in_last  = (in_cnt == num_paths);    // input side closed
    // the result firing now completes the batch
    assign out_last = out_fire && (out_cnt == num_paths - 1'b1);

    // a result can only leave for a path that already went in
    a_out_le_in: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_fire |-> out_cnt < in_cnt
    ) else $error("result count ahead of input count");

endmodule

// ==== verilog/pv_accumulator.sv ====
module pv_accumulator #(
    parameter int WIDTH    = lsm_pkg::FP_WIDTH,
    parameter int CNT_BITS = lsm_pkg::SUM_GUARD
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    input  logic                             out_fire,
    input  logic signed [WIDTH-1:0]          pv,
    output logic signed [WIDTH+CNT_BITS-1:0] pv_sum
);

    localparam int SUM_W = WIDTH + CNT_BITS;

    logic signed [SUM_W-1:0] pv_ext;

    assign pv_ext = pv;    // sign extends

    // ----------------------------------------
    // running batch sum
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pv_sum <= '0;
        end else if (clear) begin
            pv_sum <= '0;
        end else if (out_fire) begin
            pv_sum <= pv_sum + pv_ext;
        end
    end

    // batch start must not swallow a result
    a_no_add_on_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear |-> !out_fire
    ) else $error("result accepted while sum was cleared");

endmodule
